//--- design/exe_pkg.sv
package exe_pkg;

    // ########################################################################
    // Word widths
    // ########################################################################

    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  trap_t;
    typedef logic [4:0]  alu_op_t;
    typedef logic [2:0]  src_sel_t;
    typedef logic [3:0]  br_op_t;

    // ########################################################################
    // Operation codes
    // ########################################################################

    localparam alu_op_t ALU_ADD   = 5'd0;
    localparam alu_op_t ALU_SUB   = 5'd1;
    localparam alu_op_t ALU_SLL   = 5'd2;
    localparam alu_op_t ALU_SLT   = 5'd3;
    localparam alu_op_t ALU_SLTU  = 5'd4;
    localparam alu_op_t ALU_XOR   = 5'd5;
    localparam alu_op_t ALU_SRL   = 5'd6;
    localparam alu_op_t ALU_SRA   = 5'd7;
    localparam alu_op_t ALU_OR    = 5'd8;
    localparam alu_op_t ALU_AND   = 5'd9;
    localparam alu_op_t ALU_LUI   = 5'd10;
    localparam alu_op_t ALU_AUIPC = 5'd11;
    localparam alu_op_t ALU_ADDW  = 5'd12;
    localparam alu_op_t ALU_SUBW  = 5'd13;
    localparam alu_op_t ALU_SLLW  = 5'd14;
    localparam alu_op_t ALU_SRLW  = 5'd15;
    localparam alu_op_t ALU_SRAW  = 5'd16;

    localparam src_sel_t SRC_A_PC  = 3'b001; // Operand A is pc instead of rs1.
    localparam src_sel_t SRC_B_IMM = 3'b010; // Operand B is imm instead of rs2.

    localparam br_op_t BR_NONE = 4'd0;
    localparam br_op_t BR_BEQ  = 4'd1;
    localparam br_op_t BR_BNE  = 4'd2;
    localparam br_op_t BR_BLT  = 4'd3;
    localparam br_op_t BR_BGE  = 4'd4;
    localparam br_op_t BR_BLTU = 4'd5;
    localparam br_op_t BR_BGEU = 4'd6;
    localparam br_op_t BR_JAL  = 4'd7;
    localparam br_op_t BR_JALR = 4'd8;

    // Values loaded at reset.
    localparam trap_t    TRAP_NOP = 4'd0;
    localparam alu_op_t  ALU_NOP  = ALU_ADD;
    localparam src_sel_t SRC_NOP  = 3'b000;
    localparam xlen_t    PC_RESET = 64'h0000_0000_3000_0000;

    // ########################################################################
    // Packets
    // ########################################################################

    typedef struct packed {
        trap_t    trap;
        reg_idx_t rd;
        xlen_t    rs1_val;
        xlen_t    rs2_val;
        xlen_t    imm;
        xlen_t    pc;
        alu_op_t  alu_op;
        src_sel_t src_sel;
        br_op_t   br_op;
        logic     wb_en;
    } dec_pkt_t;

    typedef struct packed {
        logic     valid;
        trap_t    trap;
        reg_idx_t rd;
        xlen_t    rs1_val;
        xlen_t    rs2_val;
        xlen_t    imm;
        xlen_t    pc;
        alu_op_t  alu_op;
        src_sel_t src_sel;
        br_op_t   br_op;
        logic     wb_en;
    } exe_pkt_t;

    typedef struct packed {
        logic     valid;
        trap_t    trap;
        reg_idx_t rd;
        logic     wb_en;
        xlen_t    result;
        logic     redirect;
        xlen_t    target;
    } exe_res_t;

endpackage

//--- design/exe_reg.sv
`timescale 1ns/1ns

module exe_reg (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,
    input  logic              valid_ctrl,
    input  logic              valid_dec,
    input  exe_pkg::dec_pkt_t dec,
    output exe_pkg::exe_pkt_t pkt
);
    import exe_pkg::*;

    logic     valid_q;
    dec_pkt_t payload_q;

    // ########################################################################
    // Valid bit
    // ########################################################################

    // With enable low the bit is held. Otherwise a bubble enters unless both
    // the hazard logic and decode agree that the instruction may proceed.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (enable) begin
            valid_q <= valid_ctrl & valid_dec;
        end
    end

    // ########################################################################
    // Payload
    // ########################################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            payload_q.trap    <= TRAP_NOP;
            payload_q.rd      <= '0;
            payload_q.rs1_val <= '0;
            payload_q.rs2_val <= '0;
            payload_q.imm     <= '0;
            payload_q.pc      <= PC_RESET;
            payload_q.alu_op  <= ALU_NOP;
            payload_q.src_sel <= SRC_NOP;
            payload_q.br_op   <= BR_NONE;
            payload_q.wb_en   <= 1'b0;
        end else if (enable) begin
            payload_q <= dec; // Loaded even for a bubble.
        end
    end

    assign pkt = '{
        valid:   valid_q,
        trap:    payload_q.trap,
        rd:      payload_q.rd,
        rs1_val: payload_q.rs1_val,
        rs2_val: payload_q.rs2_val,
        imm:     payload_q.imm,
        pc:      payload_q.pc,
        alu_op:  payload_q.alu_op,
        src_sel: payload_q.src_sel,
        br_op:   payload_q.br_op,
        wb_en:   payload_q.wb_en
    };

endmodule

//--- design/exe_alu.sv
`timescale 1ns/1ns

module exe_alu (
    input  exe_pkg::exe_pkt_t pkt,
    output exe_pkg::xlen_t    alu_result
);
    import exe_pkg::*;

    xlen_t       op_a;
    xlen_t       op_b;
    logic [5:0]  shamt;
    logic [4:0]  shamt_w;
    logic [31:0] word_res;

    // ########################################################################
    // Operand selection
    // ########################################################################

    // AUIPC relies on this path to form pc + imm.
    assign op_a = (pkt.src_sel & SRC_A_PC) != SRC_NOP ? pkt.pc : pkt.rs1_val;
    assign op_b = (pkt.src_sel & SRC_B_IMM) != SRC_NOP ? pkt.imm : pkt.rs2_val;

    assign shamt   = op_b[5:0];
    assign shamt_w = op_b[4:0]; // W shifts ignore bit 5 of the amount.

    // ########################################################################
    // 32-bit W forms
    // ########################################################################

    always_comb begin
        case (pkt.alu_op)
            ALU_ADDW: begin
                word_res = op_a[31:0] + op_b[31:0];
            end
            ALU_SUBW: begin
                word_res = op_a[31:0] - op_b[31:0];
            end
            ALU_SLLW: begin
                word_res = op_a[31:0] << shamt_w;
            end
            ALU_SRLW: begin
                word_res = op_a[31:0] >> shamt_w;
            end
            ALU_SRAW: begin
                word_res = $signed(op_a[31:0]) >>> shamt_w;
            end
            default: begin
                word_res = '0;
            end
        endcase
    end

    // ########################################################################
    // Result
    // ########################################################################

    always_comb begin
        case (pkt.alu_op)
            ALU_ADD, ALU_AUIPC: begin
                alu_result = op_a + op_b;
            end
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = xlen_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_result = xlen_t'(op_a < op_b);
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_LUI:  alu_result = pkt.imm; // Decode has already shifted the immediate.
            ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW: begin
                // Word results are sign-extended to the full register.
                alu_result = {{32{word_res[31]}}, word_res};
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

//--- design/exe_branch.sv
`timescale 1ns/1ns

module exe_branch (
    input  exe_pkg::exe_pkt_t pkt,
    output exe_pkg::xlen_t    link,
    output logic              redirect,
    output exe_pkg::xlen_t    target
);
    import exe_pkg::*;

    logic  eq;
    logic  lt;
    logic  ltu;
    logic  taken;
    xlen_t pc_target;
    xlen_t reg_target;

    // ########################################################################
    // Condition
    // ########################################################################

    assign eq  = pkt.rs1_val == pkt.rs2_val;
    assign lt  = $signed(pkt.rs1_val) < $signed(pkt.rs2_val);
    assign ltu = pkt.rs1_val < pkt.rs2_val;

    always_comb begin
        case (pkt.br_op)
            BR_BEQ: begin
                taken = eq;
            end
            BR_BNE: begin
                taken = !eq;
            end
            BR_BLT: begin
                taken = lt;
            end
            BR_BGE: begin
                taken = !lt;
            end
            BR_BLTU: begin
                taken = ltu;
            end
            BR_BGEU: begin
                taken = !ltu;
            end
            BR_JAL, BR_JALR: begin
                taken = 1'b1; // Jumps always leave the sequential path.
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // ########################################################################
    // Target and link
    // ########################################################################

    assign pc_target  = pkt.pc + pkt.imm;
    assign reg_target = pkt.rs1_val + pkt.imm;

    // JALR drops bit 0 of the sum as the ISA requires.
    assign target = (pkt.br_op == BR_JALR) ? {reg_target[63:1], 1'b0} : pc_target;

    assign link     = pkt.pc + xlen_t'(4);
    assign redirect = taken; // Validity is applied in the result mux.

endmodule

//--- design/exe_result_mux.sv
`timescale 1ns/1ns

module exe_result_mux (
    input  exe_pkg::exe_pkt_t pkt,
    input  exe_pkg::xlen_t    alu_result,
    input  exe_pkg::xlen_t    link,
    input  logic              redirect,
    input  exe_pkg::xlen_t    target,
    output exe_pkg::exe_res_t res
);
    import exe_pkg::*;

    logic  is_jump;
    xlen_t result;

    // Jumps write the return address instead of the ALU value.
    assign is_jump = (pkt.br_op == BR_JAL) || (pkt.br_op == BR_JALR);
    assign result  = is_jump ? link : alu_result;

    // A bubble must not write a register or steer the fetch unit.
    // The data fields still follow the loaded packet.
    assign res = '{
        valid:    pkt.valid,
        trap:     pkt.trap,
        rd:       pkt.rd,
        wb_en:    pkt.wb_en & pkt.valid,
        result:   result,
        redirect: redirect & pkt.valid,
        target:   target
    };

endmodule

//--- design/exe_stage.sv
`timescale 1ns/1ns

module exe_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,
    input  logic              valid_ctrl,
    input  logic              valid_dec,
    input  exe_pkg::dec_pkt_t dec,
    output exe_pkg::exe_res_t res
);
    import exe_pkg::*;

    exe_pkt_t pkt;
    xlen_t    alu_result;
    xlen_t    link;
    logic     redirect;
    xlen_t    target;

    // ########################################################################
    // Pipeline register
    // ########################################################################

    exe_reg u_exe_reg (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .valid_ctrl (valid_ctrl),
        .valid_dec  (valid_dec),
        .dec        (dec),
        .pkt        (pkt)
    );

    // ########################################################################
    // Execute units
    // ########################################################################

    // Both units see the same latched packet in parallel.
    exe_alu u_exe_alu (
        .pkt        (pkt),
        .alu_result (alu_result)
    );

    exe_branch u_exe_branch (
        .pkt      (pkt),
        .link     (link),
        .redirect (redirect),
        .target   (target)
    );

    exe_result_mux u_exe_result_mux (
        .pkt        (pkt),
        .alu_result (alu_result),
        .link       (link),
        .redirect   (redirect),
        .target     (target),
        .res        (res)
    );

endmodule

//--- sim/exe_tb.sv
`timescale 1ns/1ns

module exe_tb;
    import exe_pkg::*;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_VECTORS  = 44;
    localparam int VEC_WORDS    = 20; // 13 stimulus words, then 7 expected words.
    localparam int TIMEOUT      = (NUM_VECTORS + RESET_CYCLES + 1 + 10) * PERIOD;

    logic     clk;
    logic     rst;
    logic     enable;
    logic     valid_ctrl;
    logic     valid_dec;
    dec_pkt_t dec;
    exe_res_t res;

    logic [63:0] vectors [0:NUM_VECTORS*VEC_WORDS-1];

    exe_stage u_exe_stage (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .valid_ctrl (valid_ctrl),
        .valid_dec  (valid_dec),
        .dec        (dec),
        .res        (res)
    );

    always begin
        clk = 1'b0;
        #(PERIOD / 2);
        clk = 1'b1;
        #(PERIOD / 2);
    end

    // ########################################################################
    // Helpers
    // ########################################################################

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    // The reset packet has a zero immediate, so the target shows the reset pc.
    task automatic verify_reset_state(input string tag);
        check({tag, " res.valid"}, 64'(res.valid), 64'd0);
        check({tag, " res.wb_en"}, 64'(res.wb_en), 64'd0);
        check({tag, " res.redirect"}, 64'(res.redirect), 64'd0);
        check({tag, " res.trap"}, 64'(res.trap), 64'(TRAP_NOP));
        check({tag, " res.target"}, res.target, PC_RESET);
    endtask

    // Word order follows the column comment at the top of the vector file.
    task automatic apply_vector(input int n);
        int b;
        b           = n * VEC_WORDS;
        enable      = vectors[b][0];
        valid_ctrl  = vectors[b + 1][0];
        valid_dec   = vectors[b + 2][0];
        dec.trap    = vectors[b + 3][3:0];
        dec.rd      = vectors[b + 4][4:0];
        dec.rs1_val = vectors[b + 5];
        dec.rs2_val = vectors[b + 6];
        dec.imm     = vectors[b + 7];
        dec.pc      = vectors[b + 8];
        dec.alu_op  = vectors[b + 9][4:0];
        dec.src_sel = vectors[b + 10][2:0];
        dec.br_op   = vectors[b + 11][3:0];
        dec.wb_en   = vectors[b + 12][0];
    endtask

    task automatic compare_result(input int n);
        int    b;
        string tag;
        b   = n * VEC_WORDS + 13;
        tag = $sformatf("vector %0d", n);
        check({tag, " res.valid"}, 64'(res.valid), vectors[b]);
        check({tag, " res.trap"}, 64'(res.trap), vectors[b + 1]);
        check({tag, " res.rd"}, 64'(res.rd), vectors[b + 2]);
        check({tag, " res.wb_en"}, 64'(res.wb_en), vectors[b + 3]);
        check({tag, " res.result"}, res.result, vectors[b + 4]);
        check({tag, " res.redirect"}, 64'(res.redirect), vectors[b + 5]);
        check({tag, " res.target"}, res.target, vectors[b + 6]);
    endtask

    // ########################################################################
    // Stimulus
    // ########################################################################

    initial begin
        rst        = 1'b1;
        enable     = 1'b0;
        valid_ctrl = 1'b0;
        valid_dec  = 1'b0;
        dec        = '0;
        $readmemh("sim/exe_vectors.hex", vectors);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        verify_reset_state("during reset");
        rst = 1'b0;

        // One idle cycle with the stage stalled, so the reset contents remain.
        @(negedge clk);
        verify_reset_state("after reset");

        // Each vector is loaded at the rising edge between the two falling edges.
        for (int i = 0; i < NUM_VECTORS; i++) begin
            apply_vector(i);
            @(negedge clk);
            compare_result(i);
        end

        $display("All tests passed");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d ns.", TIMEOUT);
        stop_with_failure();
    end

endmodule

//--- sim/exe_vectors.hex
// en vc vd trap rd rs1 rs2 imm pc alu_op src_sel br_op wb_en, then the expected
// result after the next rising edge: valid trap rd wb_en result redirect target
1 1 1 0 01 5 7 0 1000 00 0 0 1    1 0 01 1 c 0 1000
1 1 1 0 02 10 0 fffffffffffffffd 1000 00 2 0 1    1 0 02 1 d 0 ffd
1 1 1 0 03 3 5 0 1000 01 0 0 1    1 0 03 1 fffffffffffffffe 0 1000
1 1 1 0 04 1 7f 0 1000 02 0 0 1    1 0 04 1 8000000000000000 0 1000
1 1 1 0 05 ff 0 8 1000 02 2 0 1    1 0 05 1 ff00 0 1008
1 1 1 0 06 ffffffffffffffff 1 0 1000 03 0 0 1    1 0 06 1 1 0 1000
1 1 1 0 07 ffffffffffffffff 1 0 1000 04 0 0 1    1 0 07 1 0 0 1000
1 1 1 0 08 fffffffffffffffb 0 fffffffffffffffc 1000 03 2 0 1    1 0 08 1 1 0 ffc
1 1 1 0 09 5 0 ffffffffffffffff 1000 04 2 0 1    1 0 09 1 1 0 fff
1 1 1 0 0a f0f0 ff00 0 1000 05 0 0 1    1 0 0a 1 ff0 0 1000
1 1 1 0 0b 8000000000000000 3f 0 1000 06 0 0 1    1 0 0b 1 1 0 1000
1 1 1 0 0c 8000000000000000 3c 0 1000 07 0 0 1    1 0 0c 1 fffffffffffffff8 0 1000
1 1 1 0 0d f0 0 4 1000 07 2 0 1    1 0 0d 1 f 0 1004
1 1 1 0 0e f00 f 0 1000 08 0 0 1    1 0 0e 1 f0f 0 1000
1 1 1 0 0f 12345678 0 fff 1000 09 2 0 1    1 0 0f 1 678 0 1fff
1 1 1 0 10 99 0 ffffffff80000000 1000 0a 2 0 1    1 0 10 1 ffffffff80000000 0 ffffffff80001000
1 1 1 0 11 0 0 12000 2000 0b 3 0 1    1 0 11 1 14000 0 14000
1 1 1 0 12 7fffffff 1 0 1000 0c 0 0 1    1 0 12 1 ffffffff80000000 0 1000
1 1 1 0 13 ffffffff00000005 0 3 1000 0c 2 0 1    1 0 13 1 8 0 1003
1 1 1 0 14 0 1 0 1000 0d 0 0 1    1 0 14 1 ffffffffffffffff 0 1000
1 1 1 0 15 1 3f 0 1000 0e 0 0 1    1 0 15 1 ffffffff80000000 0 1000
1 1 1 0 16 ffffffff80000000 0 4 1000 0f 2 0 1    1 0 16 1 8000000 0 1004
1 1 1 0 17 80000000 4 0 1000 10 0 0 1    1 0 17 1 fffffffff8000000 0 1000
1 1 1 0 00 5 5 40 3000 00 0 1 0    1 0 00 0 a 1 3040
1 1 1 0 00 5 6 40 3000 00 0 1 0    1 0 00 0 b 0 3040
1 1 1 0 00 5 6 fffffffffffffff0 3000 00 0 2 0    1 0 00 0 b 1 2ff0
1 1 1 0 00 5 5 fffffffffffffff0 3000 00 0 2 0    1 0 00 0 a 0 2ff0
1 1 1 0 00 ffffffffffffffff 1 40 3000 00 0 3 0    1 0 00 0 0 1 3040
1 1 1 0 00 1 ffffffffffffffff 40 3000 00 0 3 0    1 0 00 0 0 0 3040
1 1 1 0 00 1 ffffffffffffffff 40 3000 00 0 4 0    1 0 00 0 0 1 3040
1 1 1 0 00 ffffffffffffffff 1 40 3000 00 0 4 0    1 0 00 0 0 0 3040
1 1 1 0 00 1 ffffffffffffffff 40 3000 00 0 5 0    1 0 00 0 0 1 3040
1 1 1 0 00 ffffffffffffffff 1 40 3000 00 0 5 0    1 0 00 0 0 0 3040
1 1 1 0 00 ffffffffffffffff 1 40 3000 00 0 6 0    1 0 00 0 0 1 3040
1 1 1 0 00 1 ffffffffffffffff 40 3000 00 0 6 0    1 0 00 0 0 0 3040
1 1 1 0 01 0 0 100 4000 00 3 7 1    1 0 01 1 4004 1 4100
1 1 1 0 01 5001 0 20 4100 00 2 8 1    1 0 01 1 4104 1 5020
0 1 1 0 05 1 1 0 6000 00 0 0 1    1 0 01 1 4104 1 5020
0 0 0 0 06 2 2 0 6000 00 0 0 1    1 0 01 1 4104 1 5020
1 1 1 0 05 1 1 0 6000 00 0 0 1    1 0 05 1 2 0 6000
1 0 1 3 07 0 0 8 7000 00 0 1 1    0 3 07 0 0 0 7008
1 1 0 0 08 0 0 10 7000 00 3 7 1    0 0 08 0 7004 0 7010
1 0 0 5 09 3 4 0 7000 00 0 0 1    0 5 09 0 7 0 7000
1 1 1 2 0a 1 0 1 7000 00 2 0 1    1 2 0a 1 2 0 7001

//--- files.f
design/exe_pkg.sv
design/exe_reg.sv
design/exe_alu.sv
design/exe_branch.sv
design/exe_result_mux.sv
design/exe_stage.sv
sim/exe_tb.sv

//--- run.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
    --top-module exe_tb -f files.f -o exe_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status."
    exit 1
fi

./obj_dir/exe_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status."
    exit 1
fi

exit 0
